// File: design/tcu_config.svh
`ifndef TCU_CONFIG_SVH
`define TCU_CONFIG_SVH

// word and tile geometry
`define TCU_XLEN 32
`define TCU_N 2          // words per dot product
`define TCU_TILE_M 2     // tile rows
`define TCU_TILE_N 2     // tile columns

// pipeline depth of one dot-product unit
`define TCU_FMUL_LATENCY 2
`define TCU_FACC_LATENCY 2

// beat counter, 255 beats max
`define TCU_STEP_W 8

`endif

// File: design/tcu_types_pkg.sv
`default_nettype none

`include "tcu_config.svh"

package tcu_types_pkg;

    // element formats, integer subset of the fp/int encoding
    typedef enum logic [3:0] {
        FMT_INT8  = 4'd9,
        FMT_UINT8 = 4'd10,
        FMT_INT4  = 4'd11,
        FMT_UINT4 = 4'd12
    } tcu_fmt_e;

    typedef logic [`TCU_XLEN-1:0] tcu_word_t;

    // one row of A or one column of B, as seen by a single unit
    typedef tcu_word_t [`TCU_N-1:0] tcu_row_t;

    // operand beat
    typedef struct packed {
        tcu_row_t [`TCU_TILE_M-1:0] a_rows;  // shared across columns
        tcu_row_t [`TCU_TILE_N-1:0] b_cols;  // shared across rows
    } tcu_opnd_t;

    // accumulator tile, used for C and D
    typedef struct packed {
        tcu_word_t [`TCU_TILE_M-1:0][`TCU_TILE_N-1:0] val;
    } tcu_tile_t;

endpackage

`default_nettype wire

// File: design/tcu_ctrl_pkg.sv
`default_nettype none

`include "tcu_config.svh"

package tcu_ctrl_pkg;

    // sequencer states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_RUN   = 2'd1,  // beats still being issued
        ST_DRAIN = 2'd2,  // waiting on tags in flight
        ST_DONE  = 2'd3   // one enabled cycle of done
    } tcu_state_e;

    // command word, sampled with start
    typedef struct packed {
        tcu_types_pkg::tcu_fmt_e fmt;
        logic [`TCU_STEP_W-1:0]  k_steps;  // zero means D = C
    } tcu_cmd_t;

endpackage

`default_nettype wire

// File: design/tcu_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module tcu_pipe_reg #(
    parameter int DATAW = 1,
    parameter int DEPTH = 1
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              enable,
    input  wire  [DATAW-1:0] data_in,
    output logic [DATAW-1:0] data_out
);

    if (DEPTH == 0) begin : g_pass
        assign data_out = data_in;  // no stages
    end else begin : g_chain
        logic [DEPTH-1:0][DATAW-1:0] stage;

        always_ff @(posedge clk) begin
            if (rst) begin
                stage <= '0;
            end else if (enable) begin
                stage[0] <= data_in;
                for (int i = 1; i < DEPTH; i++) begin
                    stage[i] <= stage[i-1];
                end
            end
        end

        assign data_out = stage[DEPTH-1];
    end

endmodule

`default_nettype wire

// File: design/tcu_fedp.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcu_config.svh"

module tcu_fedp (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            enable,
    input  wire tcu_types_pkg::tcu_fmt_e   fmt,
    input  wire tcu_types_pkg::tcu_row_t   a_row,
    input  wire tcu_types_pkg::tcu_row_t   b_col,
    input  wire tcu_types_pkg::tcu_word_t  c_val,
    output wire tcu_types_pkg::tcu_word_t  d_val
);
    import tcu_types_pkg::*;

    localparam int LANES8 = `TCU_XLEN / 8;
    localparam int LANES4 = `TCU_XLEN / 4;

    tcu_row_t  prod;      // per-word lane sums
    tcu_row_t  prod_r;    // after multiply stage
    tcu_word_t c_r;       // C lined up with prod_r
    tcu_word_t acc_sum;

    // lane-wise dot product of one word pair, wraps mod 2^32
    function automatic tcu_word_t word_dot(
        input tcu_fmt_e  f,
        input tcu_word_t a,
        input tcu_word_t b
    );
        tcu_word_t sum;
        tcu_word_t ax;
        tcu_word_t bx;
        logic      sgn;

        sum = '0;
        sgn = (f == FMT_INT8) || (f == FMT_INT4);
        case (f)
            FMT_INT8, FMT_UINT8: begin
                for (int j = 0; j < LANES8; j++) begin
                    ax = sgn ? tcu_word_t'($signed(a[8*j +: 8])) : tcu_word_t'(a[8*j +: 8]);
                    bx = sgn ? tcu_word_t'($signed(b[8*j +: 8])) : tcu_word_t'(b[8*j +: 8]);
                    sum = sum + ax * bx;
                end
            end
            FMT_INT4, FMT_UINT4: begin
                for (int j = 0; j < LANES4; j++) begin
                    ax = sgn ? tcu_word_t'($signed(a[4*j +: 4])) : tcu_word_t'(a[4*j +: 4]);
                    bx = sgn ? tcu_word_t'($signed(b[4*j +: 4])) : tcu_word_t'(b[4*j +: 4]);
                    sum = sum + ax * bx;
                end
            end
            default: begin
                sum = '0;  // unknown format contributes nothing
            end
        endcase
        return sum;
    endfunction

    // multiply stage
    always_comb begin
        for (int i = 0; i < `TCU_N; i++) begin
            prod[i] = word_dot(fmt, a_row[i], b_col[i]);
        end
    end

    tcu_pipe_reg #(
        .DATAW (`TCU_N * `TCU_XLEN),
        .DEPTH (`TCU_FMUL_LATENCY)
    ) u_pipe_mul (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable),
        .data_in  (prod),
        .data_out (prod_r)
    );

    // C rides alongside the products
    tcu_pipe_reg #(
        .DATAW (`TCU_XLEN),
        .DEPTH (`TCU_FMUL_LATENCY)
    ) u_pipe_c (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable),
        .data_in  (c_val),
        .data_out (c_r)
    );

    // accumulate stage
    always_comb begin
        acc_sum = c_r;
        for (int i = 0; i < `TCU_N; i++) begin
            acc_sum = acc_sum + prod_r[i];
        end
    end

    tcu_pipe_reg #(
        .DATAW (`TCU_XLEN),
        .DEPTH (`TCU_FACC_LATENCY)
    ) u_pipe_acc (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable),
        .data_in  (acc_sum),
        .data_out (d_val)
    );

endmodule

`default_nettype wire

// File: design/tcu_tile.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcu_config.svh"

module tcu_tile (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            enable,
    input  wire tcu_types_pkg::tcu_fmt_e   fmt,
    input  wire tcu_types_pkg::tcu_opnd_t  opnd,
    output wire tcu_types_pkg::tcu_tile_t  part
);

    // unit (i,j) sees row i of A and column j of B,
    // so every row feeds both columns and vice versa
    for (genvar i = 0; i < `TCU_TILE_M; i++) begin : g_row
        for (genvar j = 0; j < `TCU_TILE_N; j++) begin : g_col
            tcu_fedp u_fedp (
                .clk    (clk),
                .rst    (rst),
                .enable (enable),
                .fmt    (fmt),
                .a_row  (opnd.a_rows[i]),
                .b_col  (opnd.b_cols[j]),
                .c_val  ('0),              // C is added in the sequencer
                .d_val  (part.val[i][j])
            );
        end
    end

endmodule

`default_nettype wire

// File: design/tcu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcu_config.svh"

module tcu_sequencer (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            enable,
    input  wire                            start,
    input  wire tcu_ctrl_pkg::tcu_cmd_t    cmd,
    input  wire tcu_types_pkg::tcu_tile_t  c_tile,
    input  wire                            beat_valid,
    input  wire tcu_types_pkg::tcu_opnd_t  beat,
    input  wire tcu_types_pkg::tcu_tile_t  part,
    output tcu_types_pkg::tcu_opnd_t       tile_opnd,
    output tcu_types_pkg::tcu_fmt_e        tile_fmt,
    output tcu_types_pkg::tcu_tile_t       d_tile,
    output logic                           busy,
    output logic                           done,
    output logic                           fmt_err
);
    import tcu_types_pkg::*;
    import tcu_ctrl_pkg::*;

    localparam int LATENCY = `TCU_FMUL_LATENCY + `TCU_FACC_LATENCY;

    tcu_state_e             state;
    tcu_fmt_e               fmt_r;
    logic [`TCU_STEP_W-1:0] k_r;
    logic [`TCU_STEP_W-1:0] issued;    // beats sent into the tile
    logic [`TCU_STEP_W-1:0] returned;  // tags back out
    tcu_tile_t              acc;
    logic                   err_r;
    logic                   fmt_ok;
    logic                   beat_fire;
    logic                   tag_out;
    logic                   last_beat;
    logic                   last_tag;

    // only the integer formats are built
    always_comb begin
        case (cmd.fmt)
            FMT_INT8, FMT_UINT8, FMT_INT4, FMT_UINT4: fmt_ok = 1'b1;
            default:                                  fmt_ok = 1'b0;
        endcase
    end

    assign beat_fire = enable && (state == ST_RUN) && beat_valid;
    assign last_beat = (issued == k_r - 1'b1);
    assign last_tag  = tag_out && (returned == k_r - 1'b1);

    // valid tag, same depth as the tile
    tcu_pipe_reg #(
        .DATAW (1),
        .DEPTH (LATENCY)
    ) u_tag_pipe (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable),
        .data_in  (beat_fire),
        .data_out (tag_out)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            fmt_r    <= FMT_INT8;
            k_r      <= '0;
            issued   <= '0;
            returned <= '0;
            acc      <= '0;
            err_r    <= 1'b0;
        end else if (enable) begin
            err_r <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start && !fmt_ok) begin
                        err_r <= 1'b1;  // stay idle
                    end else if (start) begin
                        fmt_r    <= cmd.fmt;
                        k_r      <= cmd.k_steps;
                        issued   <= '0;
                        returned <= '0;
                        acc      <= c_tile;  // seed with C
                        state    <= (cmd.k_steps == '0) ? ST_DONE : ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (beat_fire) begin
                        issued <= issued + 1'b1;
                        if (last_beat) state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    if (last_tag) state <= ST_DONE;
                end
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase

            // partial tile lands on the edge its tag emerges
            if (tag_out) begin
                returned <= returned + 1'b1;
                for (int i = 0; i < `TCU_TILE_M; i++) begin
                    for (int j = 0; j < `TCU_TILE_N; j++) begin
                        acc.val[i][j] <= acc.val[i][j] + part.val[i][j];
                    end
                end
            end
        end
    end

    assign tile_opnd = beat_fire ? beat : '0;
    assign tile_fmt  = fmt_r;
    assign d_tile    = acc;  // holds until next start
    assign busy      = (state == ST_RUN) || (state == ST_DRAIN);
    assign done      = (state == ST_DONE) && enable;
    assign fmt_err   = err_r && enable;

endmodule

`default_nettype wire

// File: design/tcu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcu_config.svh"

module tcu_core (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            enable,     // freezes everything when low
    input  wire                            start,
    input  wire tcu_ctrl_pkg::tcu_cmd_t    cmd,
    input  wire tcu_types_pkg::tcu_tile_t  c_tile,
    input  wire                            beat_valid,
    input  wire tcu_types_pkg::tcu_opnd_t  beat,
    output wire tcu_types_pkg::tcu_tile_t  d_tile,
    output wire                            busy,
    output wire                            done,
    output wire                            fmt_err
);
    import tcu_types_pkg::*;

    wire tcu_opnd_t tile_opnd;  // gated beat
    wire tcu_fmt_e  tile_fmt;
    wire tcu_tile_t part;       // partial dot products

    tcu_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .start      (start),
        .cmd        (cmd),
        .c_tile     (c_tile),
        .beat_valid (beat_valid),
        .beat       (beat),
        .part       (part),
        .tile_opnd  (tile_opnd),
        .tile_fmt   (tile_fmt),
        .d_tile     (d_tile),
        .busy       (busy),
        .done       (done),
        .fmt_err    (fmt_err)
    );

    tcu_tile u_tile (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .fmt    (tile_fmt),
        .opnd   (tile_opnd),
        .part   (part)
    );

endmodule

`default_nettype wire

// File: tb/tcu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcu_config.svh"

module tcu_tb;
    import tcu_types_pkg::*;
    import tcu_ctrl_pkg::*;

    localparam int NCASES       = 12;
    localparam int GAP          = 3;  // stalled cycles per enable gap
    localparam int RESET_CYCLES = 4;
    localparam int DRAIN_LAT    = 5;  // last beat to done

    // one row of the case table
    typedef struct packed {
        logic [3:0]             fmt;
        logic [`TCU_STEP_W-1:0] k_steps;
        logic [1:0]             c_mode;   // 0 zero, 1 random, 2 all ones
        logic                   gap;      // enable low mid beats and mid drain
        logic                   bad_fmt;  // expect fmt_err
    } case_t;

    logic      clk = 1'b0;
    logic      rst;
    logic      enable;
    logic      start;
    tcu_cmd_t  cmd;
    tcu_tile_t c_tile;
    logic      beat_valid;
    tcu_opnd_t beat;
    wire tcu_tile_t d_tile;
    wire       busy;
    wire       done;
    wire       fmt_err;

    case_t       cases [NCASES];
    logic [31:0] lfsr;
    int          cycle = 0;
    int          limit;

    tcu_core UUT (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .start      (start),
        .cmd        (cmd),
        .c_tile     (c_tile),
        .beat_valid (beat_valid),
        .beat       (beat),
        .d_tile     (d_tile),
        .busy       (busy),
        .done       (done),
        .fmt_err    (fmt_err)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > limit) begin
            $display("timeout, run went past %0d cycles", limit);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0d ns %s: got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // 32-bit fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int n = 0; n < 32; n++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[30:0], lfsr[0]};  // one step per bit
        end
        return w;
    endfunction

    // reference lane dot product of one word pair
    function automatic logic [31:0] lane_dot(input logic [3:0] f, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [31:0] acc;
        logic [31:0] mask;
        logic        sgn;
        int          wdt;
        int          av;
        int          bv;
        acc = '0;
        wdt = (f == 4'd9 || f == 4'd10) ? 8 : 4;
        mask = (wdt == 8) ? 32'hff : 32'hf;
        sgn = (f == 4'd9) || (f == 4'd11);
        if (f >= 4'd9 && f <= 4'd12) begin
            for (int idx = 0; idx < 32 / wdt; idx++) begin
                av = int'((a >> (idx * wdt)) & mask);
                bv = int'((b >> (idx * wdt)) & mask);
                if (sgn && av > (int'(mask) >> 1)) av = av - int'(mask) - 1;
                if (sgn && bv > (int'(mask) >> 1)) bv = bv - int'(mask) - 1;
                acc = acc + (av * bv);  // wraps mod 2^32
            end
        end
        return acc;
    endfunction

    task automatic build_table();
        // fmt, k_steps, c_mode, gap, bad_fmt
        cases[0]  = '{4'd9,  8'd4, 2'd1, 1'b0, 1'b0};
        cases[1]  = '{4'd10, 8'd3, 2'd1, 1'b0, 1'b0};
        cases[2]  = '{4'd11, 8'd5, 2'd1, 1'b0, 1'b0};
        cases[3]  = '{4'd12, 8'd2, 2'd2, 1'b0, 1'b0};
        cases[4]  = '{4'd9,  8'd8, 2'd1, 1'b1, 1'b0};
        cases[5]  = '{4'd12, 8'd0, 2'd1, 1'b0, 1'b0};  // zero steps
        cases[6]  = '{4'd3,  8'd2, 2'd0, 1'b0, 1'b1};
        cases[7]  = '{4'd11, 8'd1, 2'd0, 1'b0, 1'b0};  // right after an error
        cases[8]  = '{4'd10, 8'd6, 2'd1, 1'b1, 1'b0};
        cases[9]  = '{4'd9,  8'd0, 2'd2, 1'b0, 1'b0};
        cases[10] = '{4'd15, 8'd4, 2'd1, 1'b0, 1'b1};
        cases[11] = '{4'd12, 8'd7, 2'd1, 1'b1, 1'b0};
    endtask

    // called and returns just after a rising edge
    task automatic stall_cycles(input int n);
        logic [31:0] held [`TCU_TILE_M][`TCU_TILE_N];
        enable     <= 1'b0;
        beat_valid <= 1'b0;
        beat       <= '0;
        @(negedge clk);
        for (int i = 0; i < `TCU_TILE_M; i++)
            for (int j = 0; j < `TCU_TILE_N; j++)
                held[i][j] = d_tile.val[i][j];
        for (int s = 1; s <= n; s++) begin
            @(posedge clk);
            if (s == n) enable <= 1'b1;
            @(negedge clk);
            check_value("busy", {31'b0, busy}, 32'd1);
            check_value("done", {31'b0, done}, 32'd0);
            for (int i = 0; i < `TCU_TILE_M; i++)
                for (int j = 0; j < `TCU_TILE_N; j++)
                    check_value("d_tile in stall", d_tile.val[i][j], held[i][j]);
        end
        @(posedge clk);
    endtask

    task automatic wait_done();
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            if (done) seen = 1'b1;
            else check_value("busy", {31'b0, busy}, 32'd1);  // high until done
        end
    endtask

    task automatic check_tile(input logic [31:0] expd [`TCU_TILE_M][`TCU_TILE_N]);
        for (int i = 0; i < `TCU_TILE_M; i++)
            for (int j = 0; j < `TCU_TILE_N; j++)
                check_value($sformatf("d_tile[%0d][%0d]", i, j), d_tile.val[i][j],
                            expd[i][j]);
    endtask

    task automatic run_case(input int idx);
        case_t       tc;
        tcu_tile_t   c_val;
        tcu_opnd_t   bt;
        logic [31:0] expd [`TCU_TILE_M][`TCU_TILE_N];
        int          last_cyc;
        int          exp_lat;
        tc = cases[idx];
        for (int i = 0; i < `TCU_TILE_M; i++) begin
            for (int j = 0; j < `TCU_TILE_N; j++) begin
                case (tc.c_mode)
                    2'd0:    c_val.val[i][j] = '0;
                    2'd1:    c_val.val[i][j] = rand_word();
                    default: c_val.val[i][j] = '1;
                endcase
                expd[i][j] = c_val.val[i][j];
            end
        end

        @(posedge clk);
        start  <= 1'b1;
        cmd    <= tcu_cmd_t'({tc.fmt, tc.k_steps});
        c_tile <= c_val;
        @(posedge clk);
        start  <= 1'b0;

        if (tc.bad_fmt) begin
            @(negedge clk);
            check_value("fmt_err", {31'b0, fmt_err}, 32'd1);
            check_value("busy", {31'b0, busy}, 32'd0);
            repeat (6) begin
                @(negedge clk);
                check_value("fmt_err", {31'b0, fmt_err}, 32'd0);
                check_value("busy", {31'b0, busy}, 32'd0);
                check_value("done", {31'b0, done}, 32'd0);
            end
        end else if (tc.k_steps == '0) begin
            @(negedge clk);  // cycle after start
            check_value("done", {31'b0, done}, 32'd1);
            check_value("busy", {31'b0, busy}, 32'd0);
            check_tile(expd);
            @(negedge clk);
            check_value("done", {31'b0, done}, 32'd0);
        end else begin
            for (int b = 0; b < int'(tc.k_steps); b++) begin
                if (tc.gap && b == int'(tc.k_steps) / 2) stall_cycles(GAP);
                for (int i = 0; i < `TCU_TILE_M; i++)
                    for (int w = 0; w < `TCU_N; w++)
                        bt.a_rows[i][w] = rand_word();
                for (int j = 0; j < `TCU_TILE_N; j++)
                    for (int w = 0; w < `TCU_N; w++)
                        bt.b_cols[j][w] = rand_word();
                for (int i = 0; i < `TCU_TILE_M; i++)
                    for (int j = 0; j < `TCU_TILE_N; j++)
                        for (int w = 0; w < `TCU_N; w++)
                            expd[i][j] = expd[i][j]
                                       + lane_dot(tc.fmt, bt.a_rows[i][w], bt.b_cols[j][w]);
                beat_valid <= 1'b1;
                beat       <= bt;
                @(negedge clk);
                check_value("busy", {31'b0, busy}, 32'd1);
                last_cyc = cycle;
                @(posedge clk);
            end
            beat_valid <= 1'b0;
            beat       <= '0;
            if (tc.gap) stall_cycles(GAP);  // stall inside the drain
            wait_done();
            exp_lat = DRAIN_LAT + (tc.gap ? GAP : 0);
            check_value("done latency", cycle - last_cyc, exp_lat);
            check_value("busy", {31'b0, busy}, 32'd0);
            check_tile(expd);
            @(negedge clk);
            check_value("done", {31'b0, done}, 32'd0);
            check_tile(expd);  // held after done
        end
    endtask

    initial begin
        rst        <= 1'b1;
        enable     <= 1'b1;
        start      <= 1'b0;
        cmd        <= '0;
        c_tile     <= '0;
        beat_valid <= 1'b0;
        beat       <= '0;
        lfsr   = 32'hc000_a6c9;
        build_table();
        limit = RESET_CYCLES;
        for (int n = 0; n < NCASES; n++)
            limit = limit + 20 + 4 * int'(cases[n].k_steps);

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("busy", {31'b0, busy}, 32'd0);
        check_value("done", {31'b0, done}, 32'd0);
        check_value("fmt_err", {31'b0, fmt_err}, 32'd0);
        check_tile('{'{32'd0, 32'd0}, '{32'd0, 32'd0}});

        for (int n = 0; n < NCASES; n++) run_case(n);

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+design
design/tcu_types_pkg.sv
design/tcu_ctrl_pkg.sv
design/tcu_pipe_reg.sv
design/tcu_fedp.sv
design/tcu_tile.sv
design/tcu_sequencer.sv
design/tcu_core.sv
tb/tcu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tcu_tb -f filelist.f -o tcu_sim

# a failing run exits nonzero, the log still decides
./obj_dir/tcu_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Verification passed" sim.log; then
    echo "result: PASS"
else
    echo "result: FAIL"
    exit 1
fi
